// ==== lane_pkg.sv ====
package lane_pkg;

    // ------------------
    // Array geometry
    // ------------------

    // Number of select lanes in the array
    localparam int num_lanes = 4;

    // Bits needed to name one lane
    localparam int lane_w = $clog2(num_lanes);

    // ------------------
    // Discard bookkeeping
    // ------------------

    // Late tokens a lane side may owe before it stalls
    localparam int discard_depth = 4;

    // Counter has to reach discard_depth itself, hence the +1
    localparam int discard_cnt_w = $clog2(discard_depth + 1);

endpackage

// ==== token_pkg.sv ====
package token_pkg;

    // ------------------
    // Payload
    // ------------------

    // Operand and result width
    localparam int data_w = 8;

    // One operand or result word
    typedef logic [data_w-1:0] data_t;

    // ------------------
    // Lane addressing
    // ------------------

    // Lane tag carried by every token
    typedef logic [lane_pkg::lane_w-1:0] lane_id_t;

    // One bit per lane for valid, ready and grant sets
    typedef logic [lane_pkg::num_lanes-1:0] lane_mask_t;

endpackage

// ==== token_dispatch.sv ====
`timescale 1ns/10ps

module token_dispatch (
    // Condition stream
    input  token_pkg::lane_id_t   cond_lane,
    input  logic                  cond_valid,
    output logic                  cond_ready,

    // True operand stream
    input  token_pkg::lane_id_t   true_lane,
    input  logic                  true_valid,
    output logic                  true_ready,

    // False operand stream
    input  token_pkg::lane_id_t   false_lane,
    input  logic                  false_valid,
    output logic                  false_ready,

    // Per-lane handshakes
    output token_pkg::lane_mask_t lane_cond_valid,
    output token_pkg::lane_mask_t lane_true_valid,
    output token_pkg::lane_mask_t lane_false_valid,
    input  token_pkg::lane_mask_t lane_cond_ready,
    input  token_pkg::lane_mask_t lane_true_ready,
    input  token_pkg::lane_mask_t lane_false_ready
);

    // One-hot valid for the addressed lane, all zero when idle
    function automatic token_pkg::lane_mask_t decode_tag(
        input token_pkg::lane_id_t tag,
        input logic                valid
    );
        token_pkg::lane_mask_t mask;
        mask      = '0;
        mask[tag] = valid;
        return mask;
    endfunction

    // ------------------
    // Valid decode
    // ------------------

    assign lane_cond_valid  = decode_tag(cond_lane, cond_valid);
    assign lane_true_valid  = decode_tag(true_lane, true_valid);
    assign lane_false_valid = decode_tag(false_lane, false_valid);

    // ------------------
    // Ready return
    // ------------------

    // Each source only sees the ready of the lane it is talking to
    assign cond_ready  = lane_cond_ready[cond_lane];
    assign true_ready  = lane_true_ready[true_lane];
    assign false_ready = lane_false_ready[false_lane];

endmodule

// ==== token_select.sv ====
`timescale 1ns/10ps

module token_select (
    input  logic              clk,
    input  logic              rst,

    // Condition token
    input  logic              cond,
    input  logic              cond_valid,
    output logic              cond_ready,

    // True operand token
    input  token_pkg::data_t  true_val,
    input  logic              true_valid,
    output logic              true_ready,

    // False operand token
    input  token_pkg::data_t  false_val,
    input  logic              false_valid,
    output logic              false_ready,

    // Selected result
    output token_pkg::data_t  result,
    output logic              result_valid,
    input  logic              result_ready
);

    logic [lane_pkg::discard_cnt_w-1:0] discard_true_cnt;
    logic [lane_pkg::discard_cnt_w-1:0] discard_false_cnt;

    logic pending_true;
    logic pending_false;
    logic room_true;
    logic room_false;
    logic pick_true;
    logic pick_false;
    logic fire;
    logic inc_true;
    logic dec_true;
    logic inc_false;
    logic dec_false;

    // Saturating up/down step; inc and dec together cancel
    function automatic logic [lane_pkg::discard_cnt_w-1:0] next_count(
        input logic [lane_pkg::discard_cnt_w-1:0] count,
        input logic                               inc,
        input logic                               dec
    );
        logic [lane_pkg::discard_cnt_w-1:0] stepped;
        stepped = count;
        if (inc && !dec && (count < lane_pkg::discard_depth)) begin
            stepped = count + 1'b1;
        end else if (dec && !inc && (count != '0)) begin
            stepped = count - 1'b1;
        end
        return stepped;
    endfunction

    // ------------------
    // Pairing rule
    // ------------------

    assign pending_true  = (discard_true_cnt != '0);
    assign pending_false = (discard_false_cnt != '0);

    // Unchosen side either has its token here or can owe one more
    assign room_true  = true_valid || (discard_true_cnt < lane_pkg::discard_depth);
    assign room_false = false_valid || (discard_false_cnt < lane_pkg::discard_depth);

    assign pick_true  = cond_valid && cond && true_valid && !pending_true && room_false;
    assign pick_false = cond_valid && !cond && false_valid && !pending_false && room_true;

    assign result_valid = pick_true || pick_false;
    assign result       = cond ? true_val : false_val;
    assign fire         = result_valid && result_ready;

    // ------------------
    // Handshakes
    // ------------------

    // While a side owes discards, every arriving token is swallowed
    assign cond_ready  = !cond_valid || fire;
    assign true_ready  = !true_valid || fire || pending_true;
    assign false_ready = !false_valid || fire || pending_false;

    // A token present on an owing side pays an old debt, so this
    // result still adds a new one
    assign inc_true  = fire && !cond && (!true_valid || pending_true);
    assign inc_false = fire && cond && (!false_valid || pending_false);
    assign dec_true  = pending_true && true_valid;
    assign dec_false = pending_false && false_valid;

    // ------------------
    // Discard counters
    // ------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            discard_true_cnt  <= '0;
            discard_false_cnt <= '0;
        end else begin
            discard_true_cnt  <= next_count(discard_true_cnt, inc_true, dec_true);
            discard_false_cnt <= next_count(discard_false_cnt, inc_false, dec_false);
        end
    end

endmodule

// ==== result_merge.sv ====
`timescale 1ns/10ps

module result_merge (
    input  logic                  clk,
    input  logic                  rst,

    // Lane results
    input  token_pkg::data_t      lane_result [lane_pkg::num_lanes],
    input  token_pkg::lane_mask_t lane_valid,
    output token_pkg::lane_mask_t lane_ready,

    // Merged output
    output token_pkg::data_t      out_data,
    output token_pkg::lane_id_t   out_lane,
    output logic                  out_valid,
    input  logic                  out_ready
);

    typedef enum logic {
        idle,
        holding
    } slot_state_t;

    slot_state_t           state;
    token_pkg::lane_id_t   rr_ptr;
    token_pkg::lane_mask_t grant;
    token_pkg::lane_id_t   grant_lane;
    token_pkg::lane_id_t   rr_next;
    logic                  grant_any;
    logic                  slot_free;

    // Slot can take a new result when empty or being drained now
    assign slot_free = (state == idle) || out_ready;

    // ------------------
    // Round-robin search
    // ------------------

    // rr_ptr holds the lane with top priority this cycle
    always_comb begin : grant_search
        int idx;
        grant      = '0;
        grant_lane = '0;
        grant_any  = 1'b0;
        for (int i = 0; i < lane_pkg::num_lanes; i++) begin
            idx = int'(rr_ptr) + i;
            if (idx >= lane_pkg::num_lanes) begin
                idx = idx - lane_pkg::num_lanes;
            end
            if (!grant_any && lane_valid[idx]) begin
                grant_any  = 1'b1;
                grant[idx] = 1'b1;
                grant_lane = token_pkg::lane_id_t'(idx);
            end
        end
    end

    // Priority moves to the lane after the one just served
    assign rr_next = (grant_lane == lane_pkg::num_lanes - 1) ? '0 : grant_lane + 1'b1;

    assign lane_ready = slot_free ? grant : '0;

    // ------------------
    // Output slot
    // ------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= idle;
            rr_ptr <= '0;
        end else if (slot_free) begin
            if (grant_any) begin
                state  <= holding;
                rr_ptr <= rr_next;
            end else begin
                state <= idle;
            end
        end
    end

    // Held steady whenever the slot is full and not accepted
    always_ff @(posedge clk) begin
        if (slot_free && grant_any) begin
            out_data <= lane_result[grant_lane];
            out_lane <= grant_lane;
        end
    end

    assign out_valid = (state == holding);

endmodule

// ==== select_array.sv ====
`timescale 1ns/10ps

module select_array (
    input  logic                clk,
    input  logic                rst,

    // Condition stream
    input  logic                cond,
    input  token_pkg::lane_id_t cond_lane,
    input  logic                cond_valid,
    output logic                cond_ready,

    // True operand stream
    input  token_pkg::data_t    true_val,
    input  token_pkg::lane_id_t true_lane,
    input  logic                true_valid,
    output logic                true_ready,

    // False operand stream
    input  token_pkg::data_t    false_val,
    input  token_pkg::lane_id_t false_lane,
    input  logic                false_valid,
    output logic                false_ready,

    // Result stream
    output token_pkg::data_t    out_data,
    output token_pkg::lane_id_t out_lane,
    output logic                out_valid,
    input  logic                out_ready
);

    token_pkg::lane_mask_t lane_cond_valid;
    token_pkg::lane_mask_t lane_cond_ready;
    token_pkg::lane_mask_t lane_true_valid;
    token_pkg::lane_mask_t lane_true_ready;
    token_pkg::lane_mask_t lane_false_valid;
    token_pkg::lane_mask_t lane_false_ready;
    token_pkg::lane_mask_t lane_result_valid;
    token_pkg::lane_mask_t lane_result_ready;
    token_pkg::data_t      lane_result [lane_pkg::num_lanes];

    // ------------------
    // Tag decode
    // ------------------

    token_dispatch i_dispatch (
        .cond_lane        (cond_lane),
        .cond_valid       (cond_valid),
        .cond_ready       (cond_ready),
        .true_lane        (true_lane),
        .true_valid       (true_valid),
        .true_ready       (true_ready),
        .false_lane       (false_lane),
        .false_valid      (false_valid),
        .false_ready      (false_ready),
        .lane_cond_valid  (lane_cond_valid),
        .lane_true_valid  (lane_true_valid),
        .lane_false_valid (lane_false_valid),
        .lane_cond_ready  (lane_cond_ready),
        .lane_true_ready  (lane_true_ready),
        .lane_false_ready (lane_false_ready)
    );

    // ------------------
    // Select lanes
    // ------------------

    // Payload goes to every lane, only the addressed one sees valid
    for (genvar g = 0; g < lane_pkg::num_lanes; g++) begin : g_lane
        token_select i_lane (
            .clk          (clk),
            .rst          (rst),
            .cond         (cond),
            .cond_valid   (lane_cond_valid[g]),
            .cond_ready   (lane_cond_ready[g]),
            .true_val     (true_val),
            .true_valid   (lane_true_valid[g]),
            .true_ready   (lane_true_ready[g]),
            .false_val    (false_val),
            .false_valid  (lane_false_valid[g]),
            .false_ready  (lane_false_ready[g]),
            .result       (lane_result[g]),
            .result_valid (lane_result_valid[g]),
            .result_ready (lane_result_ready[g])
        );
    end

    // ------------------
    // Output merge
    // ------------------

    result_merge i_merge (
        .clk         (clk),
        .rst         (rst),
        .lane_result (lane_result),
        .lane_valid  (lane_result_valid),
        .lane_ready  (lane_result_ready),
        .out_data    (out_data),
        .out_lane    (out_lane),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

// ==== select_array_assert.sv ====
`timescale 1ns/10ps

module select_array_assert (
    input logic                  clk,
    input logic                  rst,
    input token_pkg::lane_id_t   cond_lane,
    input logic                  cond_valid,
    input logic                  cond_ready,
    input token_pkg::lane_id_t   true_lane,
    input logic                  true_valid,
    input logic                  true_ready,
    input token_pkg::lane_id_t   false_lane,
    input logic                  false_valid,
    input logic                  false_ready,
    input token_pkg::lane_mask_t lane_cond_valid,
    input token_pkg::lane_mask_t lane_true_valid,
    input token_pkg::lane_mask_t lane_false_valid,
    input token_pkg::lane_mask_t lane_cond_ready,
    input token_pkg::lane_mask_t lane_true_ready,
    input token_pkg::lane_mask_t lane_false_ready,
    input token_pkg::data_t      out_data,
    input token_pkg::lane_id_t   out_lane,
    input logic                  out_valid,
    input logic                  out_ready
);

    // --------------------
    // Output channel
    // --------------------

    a_reset_idle: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high after a reset cycle");

    a_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_lane))
        else $error("output changed while stalled");

    // --------------------
    // Dispatch decode
    // --------------------

    a_cond_tag: assert property (@(posedge clk) disable iff (rst)
        lane_cond_valid == (cond_valid ? token_pkg::lane_mask_t'(1) << cond_lane : '0)
        && (!cond_valid || cond_ready == lane_cond_ready[cond_lane]))
        else $error("condition routed to wrong lane");

    a_true_tag: assert property (@(posedge clk) disable iff (rst)
        lane_true_valid == (true_valid ? token_pkg::lane_mask_t'(1) << true_lane : '0)
        && (!true_valid || true_ready == lane_true_ready[true_lane]))
        else $error("true operand routed to wrong lane");

    a_false_tag: assert property (@(posedge clk) disable iff (rst)
        lane_false_valid == (false_valid ? token_pkg::lane_mask_t'(1) << false_lane : '0)
        && (!false_valid || false_ready == lane_false_ready[false_lane]))
        else $error("false operand routed to wrong lane");

endmodule

// ==== select_array_tb.sv ====
`timescale 1ns/10ps

module select_array_tb;

    typedef struct {
        int                  gap;
        token_pkg::lane_id_t lane;
        token_pkg::data_t    value;
    } token_t;

    logic clk = 1'b0;
    logic rst;
    logic cond;
    token_pkg::lane_id_t cond_lane;
    logic cond_valid;
    logic cond_ready;
    token_pkg::data_t true_val;
    token_pkg::lane_id_t true_lane;
    logic true_valid;
    logic true_ready;
    token_pkg::data_t false_val;
    token_pkg::lane_id_t false_lane;
    logic false_valid;
    logic false_ready;
    token_pkg::data_t out_data;
    token_pkg::lane_id_t out_lane;
    logic out_valid;
    logic out_ready;

    logic [31:0] lfsr_state = 32'h1a35eb68;
    token_t stream_q [3][$];
    token_pkg::data_t exp_q [lane_pkg::num_lanes][$];
    logic held;
    token_pkg::data_t held_data;
    token_pkg::lane_id_t held_lane;

    select_array i_dut (.*);

    bind select_array select_array_assert i_assert (.*);

    always #2 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bit(output logic b);
        lfsr_state = lfsr_next(lfsr_state);
        b = lfsr_state[0];
    endtask

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input token_pkg::data_t got,
                              input token_pkg::data_t exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_lane(input string name, input token_pkg::lane_id_t got,
                              input token_pkg::lane_id_t exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    function automatic int expects_left();
        int n;
        n = 0;
        for (int i = 0; i < lane_pkg::num_lanes; i++) begin
            n += exp_q[i].size();
        end
        return n;
    endfunction

    // Stream 0 is condition, 1 true, 2 false
    task automatic drive_stream(input int which, input logic v, input token_t tok);
        case (which)
            0: begin
                cond_valid = v;
                cond = tok.value[0];
                cond_lane = tok.lane;
            end
            1: begin
                true_valid = v;
                true_val = tok.value;
                true_lane = tok.lane;
            end
            default: begin
                false_valid = v;
                false_val = tok.value;
                false_lane = tok.lane;
            end
        endcase
    endtask

    function automatic logic stream_accepts(input int which);
        case (which)
            0: return cond_valid && cond_ready;
            1: return true_valid && true_ready;
            default: return false_valid && false_ready;
        endcase
    endfunction

    task automatic send_stream(input int which);
        token_t tok;
        logic offered;
        logic sent;
        logic gate;
        int waited;
        while (stream_q[which].size() > 0) begin
            tok = stream_q[which].pop_front();
            // Idle cycles with valid low before this token
            repeat (tok.gap) begin
                @(posedge clk);
                #1;
                drive_stream(which, 1'b0, tok);
            end
            offered = 1'b0;
            sent = 1'b0;
            waited = 0;
            while (!sent) begin
                @(posedge clk);
                #1;
                if (!offered) begin
                    take_bit(gate);
                    offered = gate;
                end
                drive_stream(which, offered, tok);
                #2;
                sent = stream_accepts(which);
                waited++;
                if (waited > 300) begin
                    fail_now($sformatf("token on stream %0d lane %0d was never accepted",
                                       which, tok.lane));
                end
            end
        end
        @(posedge clk);
        #1;
        drive_stream(which, 1'b0, tok);
    endtask

    task automatic run_phase();
        int waited;
        fork
            send_stream(0);
            send_stream(1);
            send_stream(2);
        join
        waited = 0;
        while (expects_left() > 0) begin
            @(posedge clk);
            waited++;
            if (waited > 1000) begin
                fail_now("expected results did not arrive before the drain timeout");
            end
        end
        // A spurious extra result would sit in the slot by now
        repeat (4) @(posedge clk);
        #2;
        if (out_valid) begin
            fail_now("an extra result was left in the output slot");
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    // Random back-pressure, ready about three cycles in four
    always @(posedge clk) begin
        logic a;
        logic b;
        #1;
        take_bit(a);
        take_bit(b);
        out_ready = a | b;
    end

    // Output monitor, sampled one ns before the next edge
    always @(posedge clk) begin
        #3;
        if (rst) begin
            held = 1'b0;
        end else begin
            if (held) begin
                if (!out_valid) begin
                    fail_now("out_valid fell while the output was stalled");
                end
                check_data("out_data", out_data, held_data);
                check_lane("out_lane", out_lane, held_lane);
            end
            held = 1'b0;
            if (out_valid && out_ready) begin
                if (exp_q[out_lane].size() == 0) begin
                    fail_now($sformatf("unexpected result %h on lane %0d", out_data, out_lane));
                end
                check_data("out_data", out_data, exp_q[out_lane].pop_front());
            end else if (out_valid) begin
                held = 1'b1;
                held_data = out_data;
                held_lane = out_lane;
            end
        end
    end

    initial begin
        int fd;
        int code;
        int kind;
        int lane;
        int val;
        int gap;
        string line;
        token_t tok;
        rst = 1'b1;
        cond = 1'b0;
        cond_lane = '0;
        cond_valid = 1'b0;
        true_val = '0;
        true_lane = '0;
        true_valid = 1'b0;
        false_val = '0;
        false_lane = '0;
        false_valid = 1'b0;
        out_ready = 1'b0;
        held = 1'b0;
        apply_reset();
        fd = $fopen("select_array_trace.txt", "r");
        if (fd == 0) begin
            fail_now("could not open the trace file");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line[0] != "#") begin
                gap = 0;
                code = $sscanf(line, "%c %d %h %d", kind, lane, val, gap);
                tok.gap = gap;
                tok.lane = token_pkg::lane_id_t'(lane);
                tok.value = token_pkg::data_t'(val);
                case (kind)
                    "c": stream_q[0].push_back(tok);
                    "t": stream_q[1].push_back(tok);
                    "f": stream_q[2].push_back(tok);
                    "e": exp_q[lane].push_back(tok.value);
                    "r": begin
                        run_phase();
                        apply_reset();
                    end
                    default: fail_now("unknown line kind in trace file");
                endcase
            end
        end
        $fclose(fd);
        run_phase();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== select_array.f ====
lane_pkg.sv
token_pkg.sv
token_dispatch.sv
token_select.sv
result_merge.sv
select_array.sv
select_array_assert.sv
select_array_tb.sv

// ==== select_array_trace.txt ====
# kind lane value gap : kind c/t/f is a token, e is an expected result, r is a reset
# lane decimal, value hex, gap = idle cycles before the token is offered
# Lane 0 with tokens together, both condition values
c 0 1 0
t 0 11 0
f 0 21 0
e 0 11
c 0 0 0
t 0 12 0
f 0 22 0
e 0 22
# Lane 1 unchosen false token arrives late
c 1 1 0
t 1 31 0
f 1 41 20
e 1 31
c 1 0 0
t 1 32 0
f 1 42 0
e 1 42
# Lane 2 five early results, true side owes up to the full depth
c 2 0 0
c 2 0 0
c 2 0 0
c 2 0 0
c 2 0 0
f 2 51 0
f 2 52 0
f 2 53 0
f 2 54 0
f 2 55 0
t 2 61 40
t 2 62 0
t 2 63 0
t 2 64 0
t 2 65 0
e 2 51
e 2 52
e 2 53
e 2 54
e 2 55
# Interleaved over all lanes
c 3 1 0
t 3 71 0
f 3 81 0
e 3 71
c 0 1 0
t 0 13 0
f 0 23 0
e 0 13
c 1 0 0
t 1 33 0
f 1 43 0
e 1 43
c 2 1 0
t 2 66 0
f 2 56 0
e 2 66
c 3 0 0
t 3 72 0
f 3 82 0
e 3 82
c 0 0 0
t 0 14 0
f 0 24 0
e 0 24
# Leave discards owed on lanes 3 and 0, then reset
c 3 1 0
t 3 73 0
e 3 73
c 0 0 0
f 0 25 0
e 0 25
r
# After reset nothing is owed any more
c 3 0 0
t 3 74 0
f 3 84 0
e 3 84
c 0 1 0
t 0 15 0
f 0 26 0
e 0 15
c 3 1 0
t 3 75 0
f 3 85 0
e 3 75
